// ==== hw/exec_pkg.sv ====
package exec_pkg;

    localparam int prf_addr_w = 6;
    localparam int prf_depth  = 64;
    localparam int iq_depth   = 8;
    localparam int iq_ptr_w   = $clog2(iq_depth);
    localparam int iq_cnt_w   = iq_ptr_w + 1;   // room for a full queue

    typedef logic [31:0]           word;
    typedef logic [prf_addr_w-1:0] prf_addr;

    typedef enum logic [5:0] {
        uop_or,
        uop_ori,
        uop_lui,     // imm arrives pre-shifted, goes through or
        uop_and,
        uop_andi,
        uop_nor,
        uop_xor,
        uop_xori,
        uop_sll,
        uop_sllv,
        uop_srl,
        uop_srlv,
        uop_sra,
        uop_srav,
        uop_add,
        uop_addi,
        uop_addu,
        uop_addiu,
        uop_sub,
        uop_subu,
        uop_slt,
        uop_slti,
        uop_sltu,
        uop_sltiu,
        uop_mfhi,    // hi is renamed, value is source 0
        uop_jal
    } uop_e;

    typedef enum logic [2:0] {
        alu_logic,
        alu_shift,
        alu_arith,
        alu_move,
        alu_branch
    } alu_type_e;

    // renamed micro-op as it sits in the issue queue
    typedef struct packed {
        uop_e      uop;
        alu_type_e alu_type;
        word       pc;
        word       imm;
        prf_addr   op0_paddr;
        prf_addr   op1_paddr;
        logic      op0re;
        logic      op1re;
        prf_addr   dst_paddr;
        logic      dstwe;
    } uop_bundle;

    typedef struct packed {
        word rs0_data;
        word rs1_data;
    } prf_rd_data;

    // writeback record, also a register file write port
    typedef struct packed {
        logic    valid;
        logic    wen;
        prf_addr rd;
        word     wdata;
        logic    overflow;   // flag only, no trap
    } prf_wr_info;

    typedef struct packed {
        logic    wen;
        prf_addr rd;
        word     wdata;
    } bypass_info;

endpackage

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue import exec_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  uop_bundle           push_uop,
    input  logic [1:0]          pop_n,
    output uop_bundle           head0,
    output uop_bundle           head1,
    output logic [iq_cnt_w-1:0] count,
    output logic                full
);

    uop_bundle mem [iq_depth];

    logic [iq_ptr_w-1:0] head_ptr;
    logic [iq_ptr_w-1:0] head_nxt;
    logic [iq_ptr_w-1:0] tail_ptr;

    assign head_nxt = head_ptr + 1'b1;   // wraps at depth

    assign head0 = mem[head_ptr];
    assign head1 = mem[head_nxt];
    assign full  = (count == iq_cnt_w'(iq_depth));

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            head_ptr <= head_ptr + iq_ptr_w'(pop_n);
            count    <= count + iq_cnt_w'(push) - iq_cnt_w'(pop_n);
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_ptr] <= push_uop;
        end
    end

    // source must watch in_full
    assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("issue_queue: push while full");

    assert property (@(posedge clk) disable iff (rst)
        iq_cnt_w'(pop_n) <= count)
        else $error("issue_queue: pop_n %0d exceeds count %0d", pop_n, count);

endmodule

// ==== hw/issue_select.sv ====
`timescale 1ns/1ps

module issue_select import exec_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  uop_bundle           head0,
    input  uop_bundle           head1,
    input  logic [iq_cnt_w-1:0] count,
    input  prf_rd_data          rd_data0,
    input  prf_rd_data          rd_data1,
    output logic [1:0]          pop_n,
    output prf_addr [1:0]       rd_addr0,
    output prf_addr [1:0]       rd_addr1,
    output logic                ex0_valid,
    output logic                ex1_valid,
    output uop_bundle           ex0_uop,
    output uop_bundle           ex1_uop,
    output prf_rd_data          ex0_data,
    output prf_rd_data          ex1_data
);

    logic issue0;
    logic issue1;
    logic dep_src0;
    logic dep_src1;
    logic pair_dep;

    // head1 reading what head0 writes has to wait a cycle
    assign dep_src0 = head1.op0re && (head1.op0_paddr == head0.dst_paddr);
    assign dep_src1 = head1.op1re && (head1.op1_paddr == head0.dst_paddr);
    assign pair_dep = head0.dstwe && (dep_src0 || dep_src1);

    assign issue0 = (count != '0);
    assign issue1 = (count >= iq_cnt_w'(2)) && !pair_dep;

    always_comb begin
        if (issue1) begin
            pop_n = 2'd2;
        end else if (issue0) begin
            pop_n = 2'd1;
        end else begin
            pop_n = 2'd0;
        end
    end

    // index 0 is source 0, index 1 is source 1
    assign rd_addr0[0] = head0.op0_paddr;
    assign rd_addr0[1] = head0.op1_paddr;
    assign rd_addr1[0] = head1.op0_paddr;
    assign rd_addr1[1] = head1.op1_paddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex0_valid <= 1'b0;
            ex1_valid <= 1'b0;
        end else begin
            ex0_valid <= issue0;
            ex1_valid <= issue1;   // bubble otherwise
        end
    end

    // lane payload, qualified by the valids
    always_ff @(posedge clk) begin
        ex0_uop  <= head0;
        ex1_uop  <= head1;
        ex0_data <= rd_data0;
        ex1_data <= rd_data1;
    end

    // lane 1 never runs ahead of lane 0, keeps results in order
    assert property (@(posedge clk) disable iff (rst)
        ex1_valid |-> ex0_valid)
        else $error("issue_select: lane 1 issued without lane 0");

endmodule

// ==== hw/prf.sv ====
`timescale 1ns/1ps

module prf import exec_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  prf_addr [1:0] rd_addr0,
    input  prf_addr [1:0] rd_addr1,
    input  prf_wr_info    wr0,
    input  prf_wr_info    wr1,
    output prf_rd_data    rd_data0,
    output prf_rd_data    rd_data1
);

    word regs [prf_depth];

    // write-through read, wr1 is the younger write
    function automatic word read_port(input prf_addr addr, input prf_wr_info w0,
                                      input prf_wr_info w1, input word stored);
        if (w1.valid && w1.wen && (w1.rd == addr)) begin
            return w1.wdata;
        end else if (w0.valid && w0.wen && (w0.rd == addr)) begin
            return w0.wdata;
        end
        return stored;
    endfunction

    assign rd_data0.rs0_data = read_port(rd_addr0[0], wr0, wr1, regs[rd_addr0[0]]);
    assign rd_data0.rs1_data = read_port(rd_addr0[1], wr0, wr1, regs[rd_addr0[1]]);
    assign rd_data1.rs0_data = read_port(rd_addr1[0], wr0, wr1, regs[rd_addr1[0]]);
    assign rd_data1.rs1_data = read_port(rd_addr1[1], wr0, wr1, regs[rd_addr1[1]]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < prf_depth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0.valid && wr0.wen) begin
                regs[wr0.rd] <= wr0.wdata;
            end
            if (wr1.valid && wr1.wen) begin
                regs[wr1.rd] <= wr1.wdata;
            end
        end
    end

    // renaming gives every in-flight result its own register
    assert property (@(posedge clk) disable iff (rst)
        (wr0.valid && wr0.wen && wr1.valid && wr1.wen) |-> (wr0.rd != wr1.rd))
        else $error("prf: both write ports target p%0d", wr0.rd);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  uop_bundle  uops,
    input  prf_rd_data rdata,
    input  bypass_info bypass_alu0,
    input  bypass_info bypass_alu1,
    output prf_wr_info wb,
    output bypass_info bypass
);

    logic bp0_src0;
    logic bp0_src1;
    logic bp1_src0;
    logic bp1_src1;
    word  src0;
    word  src1;
    word  logic_res;
    word  shift_res;
    word  arith_res;
    word  addend;
    word  sum;
    word  result;
    logic is_sub;
    logic overflow;

    logic    wb_valid;
    logic    wb_wen;
    prf_addr wb_rd;
    word     wb_wdata;
    logic    wb_ovf;

    // bypass only for sources that are actually read
    assign bp0_src0 = uops.op0re && bypass_alu0.wen && (bypass_alu0.rd == uops.op0_paddr);
    assign bp0_src1 = uops.op1re && bypass_alu0.wen && (bypass_alu0.rd == uops.op1_paddr);
    assign bp1_src0 = uops.op0re && bypass_alu1.wen && (bypass_alu1.rd == uops.op0_paddr);
    assign bp1_src1 = uops.op1re && bypass_alu1.wen && (bypass_alu1.rd == uops.op1_paddr);

    assign src0 = bp0_src0 ? bypass_alu0.wdata :
                  bp1_src0 ? bypass_alu1.wdata : rdata.rs0_data;
    assign src1 = !uops.op1re ? uops.imm :
                  bp0_src1    ? bypass_alu0.wdata :
                  bp1_src1    ? bypass_alu1.wdata : rdata.rs1_data;

    always_comb begin
        case (uops.uop)
            uop_or, uop_ori, uop_lui: logic_res = src0 | src1;
            uop_and, uop_andi:        logic_res = src0 & src1;
            uop_nor:                  logic_res = ~(src0 | src1);
            uop_xor, uop_xori:        logic_res = src0 ^ src1;
            default:                  logic_res = '0;
        endcase
    end

    // amount in src0, value in src1
    always_comb begin
        case (uops.uop)
            uop_sll, uop_sllv: shift_res = src1 << src0[4:0];
            uop_srl, uop_srlv: shift_res = src1 >> src0[4:0];
            uop_sra, uop_srav: shift_res = $signed(src1) >>> src0[4:0];   // sign fill
            default:           shift_res = '0;
        endcase
    end

    // subtract as src0 + ~src1 + 1
    assign is_sub = (uops.uop == uop_sub) || (uops.uop == uop_subu);
    assign addend = is_sub ? ~src1 : src1;
    assign sum    = src0 + addend + {31'b0, is_sub};

    always_comb begin
        case (uops.uop)
            uop_slt, uop_slti:   arith_res = {31'b0, $signed(src0) < $signed(src1)};
            uop_sltu, uop_sltiu: arith_res = {31'b0, src0 < src1};
            default:             arith_res = sum;
        endcase
    end

    assign overflow = (src0[31] == addend[31]) && (sum[31] != src0[31]) &&
                      ((uops.uop == uop_add) || (uops.uop == uop_addi) ||
                       (uops.uop == uop_sub));

    always_comb begin
        case (uops.alu_type)
            alu_logic:  result = logic_res;
            alu_shift:  result = shift_res;
            alu_arith:  result = arith_res;
            alu_move:   result = src0;
            alu_branch: result = uops.pc + 32'd8;   // link address
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= in_valid;
            wb_wen   <= in_valid && uops.dstwe;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= uops.dst_paddr;
        wb_wdata <= result;
        wb_ovf   <= in_valid && overflow;
    end

    assign wb     = '{valid: wb_valid, wen: wb_wen, rd: wb_rd, wdata: wb_wdata,
                      overflow: wb_ovf};
    assign bypass = '{wen: wb_wen, rd: wb_rd, wdata: wb_wdata};

endmodule

// ==== hw/exec_cluster_top.sv ====
`timescale 1ns/1ps

module exec_cluster_top import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_push,
    input  uop_bundle  in_uop,
    output logic       in_full,
    output prf_wr_info wb0,
    output prf_wr_info wb1
);

    uop_bundle           head0;
    uop_bundle           head1;
    logic [iq_cnt_w-1:0] count;
    logic [1:0]          pop_n;
    prf_addr [1:0]       rd_addr0;
    prf_addr [1:0]       rd_addr1;
    prf_rd_data          rd_data0;
    prf_rd_data          rd_data1;
    logic                ex0_valid;
    logic                ex1_valid;
    uop_bundle           ex0_uop;
    uop_bundle           ex1_uop;
    prf_rd_data          ex0_data;
    prf_rd_data          ex1_data;
    bypass_info          bypass0;
    bypass_info          bypass1;

    issue_queue u_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (in_push),
        .push_uop (in_uop),
        .pop_n    (pop_n),
        .head0    (head0),
        .head1    (head1),
        .count    (count),
        .full     (in_full)
    );

    issue_select u_select (
        .clk       (clk),
        .rst       (rst),
        .head0     (head0),
        .head1     (head1),
        .count     (count),
        .rd_data0  (rd_data0),
        .rd_data1  (rd_data1),
        .pop_n     (pop_n),
        .rd_addr0  (rd_addr0),
        .rd_addr1  (rd_addr1),
        .ex0_valid (ex0_valid),
        .ex1_valid (ex1_valid),
        .ex0_uop   (ex0_uop),
        .ex1_uop   (ex1_uop),
        .ex0_data  (ex0_data),
        .ex1_data  (ex1_data)
    );

    // write ports fed straight from the lane wb registers
    prf u_prf (
        .clk      (clk),
        .rst      (rst),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .wr0      (wb0),
        .wr1      (wb1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    alu alu0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ex0_valid),
        .uops        (ex0_uop),
        .rdata       (ex0_data),
        .bypass_alu0 (bypass0),
        .bypass_alu1 (bypass1),
        .wb          (wb0),
        .bypass      (bypass0)
    );

    alu alu1 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ex1_valid),
        .uops        (ex1_uop),
        .rdata       (ex1_data),
        .bypass_alu0 (bypass0),
        .bypass_alu1 (bypass1),
        .wb          (wb1),
        .bypass      (bypass1)
    );

endmodule

// ==== sim/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int n_total     = 40 + 40 + 24 + 24 + 24 + 8;   // pushes over all tests
    localparam int cycle_limit = 10 * n_total + 100;

    typedef struct {
        prf_wr_info rec;
        int         tid;
    } exp_entry;

    logic       clk = 1'b0;
    logic       rst;
    logic       in_push;
    uop_bundle  in_uop;
    logic       in_full;
    prf_wr_info wb0;
    prf_wr_info wb1;

    word         model_rf [prf_depth];
    exp_entry    exp_q [$];   // results in program order
    prf_wr_info  exp0 = '0;
    prf_wr_info  exp1 = '0;
    logic        exp0_ok = 1'b0;
    logic        exp1_ok = 1'b0;
    int          exp0_tid = 0;
    int          exp1_tid = 0;
    logic [31:0] lfsr = 32'd44;
    logic        full_at_negedge = 1'b0;
    prf_addr     next_dst = prf_addr'(1);   // p0 stays zero
    prf_addr     last_dst = '0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          full_count = 0;
    int          dual_count = 0;

    string test_names [6] = '{"logic_shift", "arith_compare", "dep_chain",
                              "indep_pairs", "queue_full", "move_link"};
    uop_e logic_ops [14] = '{uop_or, uop_ori, uop_lui, uop_and, uop_andi, uop_nor,
                             uop_xor, uop_xori, uop_sll, uop_sllv, uop_srl, uop_srlv,
                             uop_sra, uop_srav};
    uop_e arith_ops [10] = '{uop_add, uop_addi, uop_addu, uop_addiu, uop_sub, uop_subu,
                             uop_slt, uop_slti, uop_sltu, uop_sltiu};
    uop_e chain_ops [4]  = '{uop_add, uop_xor, uop_subu, uop_sllv};

    always #20 clk = ~clk;

    exec_cluster_top dut (
        .clk     (clk),
        .rst     (rst),
        .in_push (in_push),
        .in_uop  (in_uop),
        .in_full (in_full),
        .wb0     (wb0),
        .wb1     (wb1)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic is_imm(input uop_e op);
        return op inside {uop_ori, uop_lui, uop_andi, uop_xori, uop_sll, uop_srl, uop_sra,
                          uop_addi, uop_addiu, uop_slti, uop_sltiu};
    endfunction

    function automatic alu_type_e class_of(input uop_e op);
        if (op inside {uop_sll, uop_sllv, uop_srl, uop_srlv, uop_sra, uop_srav}) begin
            return alu_shift;
        end else if (op inside {uop_add, uop_addi, uop_addu, uop_addiu, uop_sub, uop_subu,
                                uop_slt, uop_slti, uop_sltu, uop_sltiu}) begin
            return alu_arith;
        end else if (op == uop_mfhi) begin
            return alu_move;
        end else if (op == uop_jal) begin
            return alu_branch;
        end
        return alu_logic;
    endfunction

    // reference result from the model register file
    function automatic prf_wr_info model_exec(input uop_bundle u);
        word         a;
        word         b;
        word         r;
        logic [32:0] wide;
        a    = u.op0re ? model_rf[u.op0_paddr] : '0;
        b    = u.op1re ? model_rf[u.op1_paddr] : u.imm;
        wide = '0;
        case (u.uop)
            uop_or, uop_ori, uop_lui: r = a | b;
            uop_and, uop_andi:        r = a & b;
            uop_nor:                  r = ~(a | b);
            uop_xor, uop_xori:        r = a ^ b;
            uop_sll, uop_sllv:        r = b << a[4:0];
            uop_srl, uop_srlv:        r = b >> a[4:0];
            uop_sra, uop_srav: begin
                // vacated top bits take the sign
                r = (b >> a[4:0]) | ({32{b[31]}} & ~(32'hFFFF_FFFF >> a[4:0]));
            end
            uop_add, uop_addi, uop_addu, uop_addiu: begin
                wide = {a[31], a} + {b[31], b};
                r    = wide[31:0];
            end
            uop_sub, uop_subu: begin
                wide = {a[31], a} - {b[31], b};
                r    = wide[31:0];
            end
            uop_slt, uop_slti:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            uop_sltu, uop_sltiu: r = (a < b) ? 32'd1 : 32'd0;
            uop_mfhi:            r = a;
            default:             r = u.pc + 32'd8;   // jal link
        endcase
        return '{valid: 1'b1, wen: u.dstwe, rd: u.dst_paddr, wdata: r,
                 overflow: (wide[32] != wide[31]) && (u.uop inside {uop_add, uop_addi, uop_sub})};
    endfunction

    task automatic push_op(input int tid, input uop_e op, input prf_addr s0, input prf_addr s1);
        uop_bundle u;
        exp_entry  e;
        while (full_at_negedge) begin
            in_push <= 1'b0;
            @(posedge clk);
        end
        u.uop       = op;
        u.alu_type  = class_of(op);
        u.pc        = rand_bits(30) << 2;
        u.imm       = (op == uop_lui) ? rand_bits(16) << 16 : rand_bits(32);
        u.op0_paddr = s0;
        u.op1_paddr = is_imm(op) ? '0 : s1;
        u.op0re     = (op != uop_jal);
        u.op1re     = !is_imm(op) && (op != uop_mfhi) && (op != uop_jal);
        u.dst_paddr = next_dst;
        u.dstwe     = 1'b1;
        last_dst    = next_dst;
        next_dst    = (next_dst == prf_addr'(prf_depth - 1)) ? prf_addr'(1) : next_dst + 1'b1;
        e.rec = model_exec(u);
        e.tid = tid;
        exp_q.push_back(e);
        model_rf[u.dst_paddr] = e.rec.wdata;   // model runs ahead of the DUT
        in_uop  <= u;
        in_push <= 1'b1;
        @(posedge clk);
    endtask

    task automatic random_ops(input int tid, input int n, input bit arith);
        uop_e op;
        for (int i = 0; i < n; i++) begin
            op = arith ? arith_ops[rand_bits(8) % 10] : logic_ops[rand_bits(8) % 14];
            push_op(tid, op, prf_addr'(rand_bits(6)), prf_addr'(rand_bits(6)));
        end
    endtask

    // wb is stable here so the entries line up for the next edge
    always @(negedge clk) begin
        exp0_ok = (exp_q.size() > 0);
        exp1_ok = (exp_q.size() > 1);
        if (exp0_ok) begin
            exp0     = exp_q[0].rec;
            exp0_tid = exp_q[0].tid;
        end
        if (exp1_ok) begin
            exp1     = exp_q[1].rec;
            exp1_tid = exp_q[1].tid;
        end
        if (wb0.valid === 1'b1 && exp_q.size() > 0) exp_q.delete(0);
        if (wb1.valid === 1'b1 && exp_q.size() > 0) exp_q.delete(0);
        if (wb0.valid === 1'b1 && wb1.valid === 1'b1) dual_count++;
        if (in_full === 1'b1) full_count++;
        full_at_negedge = (in_full === 1'b1);
    end

    assert property (@(posedge clk) $fell(rst) |->
        !in_full && !wb0.valid && !wb1.valid && !wb0.wen && !wb1.wen)
        else begin
            other_errors++;
            $display("outputs were not idle right after reset");
        end

    assert property (@(posedge clk) disable iff (rst) wb0.valid |-> exp0_ok)
        else begin
            other_errors++;
            $display("lane 0 wrote back a result that no pushed micro-op expects");
        end

    assert property (@(posedge clk) disable iff (rst) wb1.valid |-> exp1_ok)
        else begin
            other_errors++;
            $display("lane 1 wrote back a result that no pushed micro-op expects");
        end

    assert property (@(posedge clk) disable iff (rst) (wb0.valid && exp0_ok) |-> wb0 == exp0)
        else begin
            value_errors++;
            $display("[ERROR] %s lane 0 expected %h actual %h",
                     test_names[exp0_tid], exp0, $sampled(wb0));
        end

    assert property (@(posedge clk) disable iff (rst) (wb1.valid && exp1_ok) |-> wb1 == exp1)
        else begin
            value_errors++;
            $display("[ERROR] %s lane 1 expected %h actual %h",
                     test_names[exp1_tid], exp1, $sampled(wb1));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results never came back",
                     cycles, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        rst     = 1'b1;
        in_push = 1'b0;
        in_uop  = '0;
        for (int i = 0; i < prf_depth; i++) begin
            model_rf[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // seed registers with random words through ori from p0
        for (int i = 0; i < 8; i++) begin
            push_op(0, uop_ori, '0, '0);
        end
        random_ops(0, 32, 1'b0);
        random_ops(1, 40, 1'b1);
        for (int i = 0; i < 24; i++) begin
            push_op(2, chain_ops[i % 4], last_dst, (i % 2) ? last_dst : prf_addr'(rand_bits(6)));
        end
        random_ops(3, 24, 1'b1);
        random_ops(4, 24, 1'b0);   // pushed back to back and gated by in_full
        for (int i = 0; i < 8; i++) begin
            push_op(5, (i % 2) ? uop_jal : uop_mfhi, prf_addr'(rand_bits(6)), '0);
        end
        in_push <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("queue full seen in %0d cycles, dual writeback seen in %0d cycles",
                 full_count, dual_count);
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/exec_pkg.sv
hw/issue_queue.sv
hw/issue_select.sv
hw/prf.sv
hw/alu.sv
hw/exec_cluster_top.sv
sim/tb_exec_cluster.sv
